//--- hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

        typedef logic [31:0] word_t;
        typedef logic [4:0]  reg_idx_t;
        typedef logic [5:0]  opcode_t;
        typedef logic [5:0]  funct_t;

        // Primary opcodes
        localparam opcode_t OP_SPECIAL = 6'b000000;
        localparam opcode_t OP_ADDI    = 6'b001000;
        localparam opcode_t OP_ADDIU   = 6'b001001;
        localparam opcode_t OP_SLTI    = 6'b001010;
        localparam opcode_t OP_SLTIU   = 6'b001011;
        localparam opcode_t OP_ANDI    = 6'b001100;
        localparam opcode_t OP_ORI     = 6'b001101;
        localparam opcode_t OP_XORI    = 6'b001110;
        localparam opcode_t OP_LUI     = 6'b001111;

        // SPECIAL funct codes
        localparam funct_t FN_SLL  = 6'b000000;
        localparam funct_t FN_SRL  = 6'b000010;
        localparam funct_t FN_SRA  = 6'b000011;
        localparam funct_t FN_SLLV = 6'b000100;
        localparam funct_t FN_SRLV = 6'b000110;
        localparam funct_t FN_SRAV = 6'b000111;
        localparam funct_t FN_ADD  = 6'b100000;
        localparam funct_t FN_ADDU = 6'b100001;
        localparam funct_t FN_SUB  = 6'b100010;
        localparam funct_t FN_SUBU = 6'b100011;
        localparam funct_t FN_AND  = 6'b100100;
        localparam funct_t FN_OR   = 6'b100101;
        localparam funct_t FN_XOR  = 6'b100110;
        localparam funct_t FN_NOR  = 6'b100111;
        localparam funct_t FN_SLT  = 6'b101010;
        localparam funct_t FN_SLTU = 6'b101011;

        typedef enum logic [3:0] {
                ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
                ALU_SLT, ALU_SLTU,
                ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
                ALU_LUI,
                ALU_SLL, ALU_SRL, ALU_SRA
        } alu_op_e;

        // Operand B source; register shifts take the count from rs
        typedef enum logic [1:0] {
                SRC_REG, SRC_IMM, SRC_SFT
        } src_e;

        typedef struct packed {
                logic     valid;
                alu_op_e  alu_op;
                src_e     src;
                logic     imm_zero_ext;
                reg_idx_t rs;
                reg_idx_t rt;
                reg_idx_t dest;
                logic [15:0] imm;
                logic [4:0]  shamt;
                logic     wb_en;
                logic     ovf_trap;      // Trap on signed overflow
                logic     undefined;
        } decoded_t;

        typedef struct packed {
                logic     valid;
                logic     wb_en;
                reg_idx_t dest;
                word_t    data;
                logic     overflow;
                logic     undefined;
        } result_t;

endpackage

`default_nettype wire

//--- hw/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import mips_pkg::*; (
        input  logic     clk,
        input  logic     reset,
        input  logic     inst_valid,
        input  word_t    instruction,
        output decoded_t dec
);

        opcode_t     opcode;
        funct_t      funct;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [4:0]  shamt;
        logic [15:0] imm;
        decoded_t    base;
        decoded_t    dec_next;

        assign opcode = instruction[31:26];
        assign rs     = instruction[25:21];
        assign rt     = instruction[20:16];
        assign rd     = instruction[15:11];
        assign shamt  = instruction[10:6];
        assign funct  = instruction[5:0];
        assign imm    = instruction[15:0];

        // Fills the control fields of one table row
        function automatic decoded_t entry(decoded_t b, alu_op_e op, src_e src,
                                           logic zext, logic trap);
                decoded_t d;
                d              = b;
                d.alu_op       = op;
                d.src          = src;
                d.imm_zero_ext = zext;
                d.ovf_trap     = trap;
                d.wb_en        = 1'b1;
                d.undefined    = 1'b0;
                d.dest         = (src == SRC_IMM) ? b.rt : rd; // I-type writes rt
                return d;
        endfunction

        always_comb begin
                base              = '0;
                base.valid        = inst_valid;
                base.alu_op       = ALU_ADDU;
                base.src          = SRC_REG;
                base.rs           = rs;
                base.rt           = rt;
                base.imm          = imm;
                base.shamt        = shamt;
                base.undefined    = 1'b1; // Unless a row matches
                dec_next          = base;
                casez ({opcode, funct})
                        {OP_SPECIAL, FN_ADD}:  dec_next = entry(base, ALU_ADD,  SRC_REG, 1'b0, 1'b1);
                        {OP_SPECIAL, FN_ADDU}: dec_next = entry(base, ALU_ADDU, SRC_REG, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_SUB}:  dec_next = entry(base, ALU_SUB,  SRC_REG, 1'b0, 1'b1);
                        {OP_SPECIAL, FN_SUBU}: dec_next = entry(base, ALU_SUBU, SRC_REG, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_SLT}:  dec_next = entry(base, ALU_SLT,  SRC_REG, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_SLTU}: dec_next = entry(base, ALU_SLTU, SRC_REG, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_AND}:  dec_next = entry(base, ALU_AND,  SRC_REG, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_OR}:   dec_next = entry(base, ALU_OR,   SRC_REG, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_XOR}:  dec_next = entry(base, ALU_XOR,  SRC_REG, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_NOR}:  dec_next = entry(base, ALU_NOR,  SRC_REG, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_SLL}:  dec_next = entry(base, ALU_SLL,  SRC_SFT, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_SRL}:  dec_next = entry(base, ALU_SRL,  SRC_SFT, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_SRA}:  dec_next = entry(base, ALU_SRA,  SRC_SFT, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_SLLV}: dec_next = entry(base, ALU_SLL,  SRC_REG, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_SRLV}: dec_next = entry(base, ALU_SRL,  SRC_REG, 1'b0, 1'b0);
                        {OP_SPECIAL, FN_SRAV}: dec_next = entry(base, ALU_SRA,  SRC_REG, 1'b0, 1'b0);
                        {OP_ADDI,  6'b??????}: dec_next = entry(base, ALU_ADD,  SRC_IMM, 1'b0, 1'b1);
                        {OP_ADDIU, 6'b??????}: dec_next = entry(base, ALU_ADDU, SRC_IMM, 1'b0, 1'b0);
                        {OP_SLTI,  6'b??????}: dec_next = entry(base, ALU_SLT,  SRC_IMM, 1'b0, 1'b0);
                        {OP_SLTIU, 6'b??????}: dec_next = entry(base, ALU_SLTU, SRC_IMM, 1'b0, 1'b0);
                        {OP_ANDI,  6'b??????}: dec_next = entry(base, ALU_AND,  SRC_IMM, 1'b1, 1'b0);
                        {OP_ORI,   6'b??????}: dec_next = entry(base, ALU_OR,   SRC_IMM, 1'b1, 1'b0);
                        {OP_XORI,  6'b??????}: dec_next = entry(base, ALU_XOR,  SRC_IMM, 1'b1, 1'b0);
                        {OP_LUI,   6'b??????}: dec_next = entry(base, ALU_LUI,  SRC_IMM, 1'b1, 1'b0);
                        default:               dec_next = base; // No writeback
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        dec <= '0;
                end else begin
                        dec <= dec_next;
                end
        end

endmodule

`default_nettype wire

//--- hw/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute import mips_pkg::*; (
        input  logic     clk,
        input  logic     reset,
        input  decoded_t dec,
        output reg_idx_t rs_idx,
        output reg_idx_t rt_idx,
        input  word_t    rs_data,
        input  word_t    rt_data,
        input  result_t  wb_fwd,
        output result_t  res
);

        word_t      rs_val;
        word_t      rt_val;
        word_t      imm_ext;
        word_t      op_b;
        logic [4:0] sh_amt;
        word_t      sum;
        word_t      diff;
        word_t      alu_out;
        logic       ovf;
        result_t    res_next;

        // Newest producer wins, r0 never bypassed
        function automatic word_t bypass(reg_idx_t idx, word_t rf_val,
                                         result_t ex, result_t wb);
                if (idx == '0)
                        return rf_val;
                if (ex.valid && ex.wb_en && ex.dest == idx)
                        return ex.data;
                if (wb.valid && wb.wb_en && wb.dest == idx)
                        return wb.data;
                return rf_val;
        endfunction

        assign rs_idx = dec.rs;
        assign rt_idx = dec.rt;
        assign rs_val = bypass(dec.rs, rs_data, res, wb_fwd);
        assign rt_val = bypass(dec.rt, rt_data, res, wb_fwd);

        assign imm_ext = dec.imm_zero_ext ? {16'b0, dec.imm} : {{16{dec.imm[15]}}, dec.imm};
        assign op_b    = (dec.src == SRC_IMM) ? imm_ext : rt_val;
        assign sh_amt  = (dec.src == SRC_SFT) ? dec.shamt : rs_val[4:0];
        assign sum     = rs_val + op_b;
        assign diff    = rs_val - op_b;

        always_comb begin
                ovf = 1'b0;
                case (dec.alu_op)
                        ALU_ADD, ALU_ADDU: begin
                                alu_out = sum;
                                ovf     = (rs_val[31] == op_b[31]) && (sum[31] != rs_val[31]);
                        end
                        ALU_SUB, ALU_SUBU: begin
                                alu_out = diff;
                                ovf     = (rs_val[31] != op_b[31]) && (diff[31] != rs_val[31]);
                        end
                        ALU_SLT:  alu_out = {31'b0, $signed(rs_val) < $signed(op_b)};
                        ALU_SLTU: alu_out = {31'b0, rs_val < op_b};
                        ALU_AND:  alu_out = rs_val & op_b;
                        ALU_OR:   alu_out = rs_val | op_b;
                        ALU_XOR:  alu_out = rs_val ^ op_b;
                        ALU_NOR:  alu_out = ~(rs_val | op_b);
                        ALU_LUI:  alu_out = {dec.imm, 16'b0};
                        ALU_SLL:  alu_out = rt_val << sh_amt;
                        ALU_SRL:  alu_out = rt_val >> sh_amt;
                        ALU_SRA:  alu_out = $signed(rt_val) >>> sh_amt;
                        default:  alu_out = sum;
                endcase
        end

        always_comb begin
                res_next.valid     = dec.valid;
                res_next.dest      = dec.dest;
                res_next.data      = alu_out;
                res_next.overflow  = dec.ovf_trap & ovf;
                res_next.wb_en     = dec.wb_en & ~(dec.ovf_trap & ovf); // Trap kills the write
                res_next.undefined = dec.undefined;
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        res <= '0;
                end else begin
                        res <= res_next;
                end
        end

endmodule

`default_nettype wire

//--- hw/reg_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module reg_writeback import mips_pkg::*; (
        input  logic     clk,
        input  logic     reset,
        input  result_t  res,
        input  reg_idx_t rs_idx,
        input  reg_idx_t rt_idx,
        output word_t    rs_data,
        output word_t    rt_data,
        output result_t  wb_fwd,
        output logic     wb_valid,
        output reg_idx_t wb_dest,
        output word_t    wb_data,
        output logic     exc_overflow,
        output logic     exc_undefined
);

        word_t regs [32];
        logic  wr_en;

        assign wr_en = res.valid && res.wb_en && (res.dest != '0);

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wr_en) begin
                        regs[res.dest] <= res.data;
                end
        end

        assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
        assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

        // Output stage, also the second bypass source
        always_ff @(posedge clk) begin
                if (reset) begin
                        wb_fwd <= '0;
                end else begin
                        wb_fwd <= res;
                end
        end

        assign wb_valid      = wb_fwd.valid & wb_fwd.wb_en;
        assign wb_dest       = wb_fwd.dest;
        assign wb_data       = wb_fwd.data;
        assign exc_overflow  = wb_fwd.valid & wb_fwd.overflow;
        assign exc_undefined = wb_fwd.valid & wb_fwd.undefined;

endmodule

`default_nettype wire

//--- hw/mips_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu_core import mips_pkg::*; (
        input  logic     clk,
        input  logic     reset,
        input  logic     inst_valid,
        input  word_t    instruction,
        output logic     wb_valid,
        output reg_idx_t wb_dest,
        output word_t    wb_data,
        output logic     exc_overflow,
        output logic     exc_undefined
);

        decoded_t dec;
        result_t  res;
        result_t  wb_fwd;
        reg_idx_t rs_idx;
        reg_idx_t rt_idx;
        word_t    rs_data;
        word_t    rt_data;

        inst_decoder u_decoder (
                .clk         (clk),
                .reset       (reset),
                .inst_valid  (inst_valid),
                .instruction (instruction),
                .dec         (dec)
        );

        alu_execute u_execute (
                .clk     (clk),
                .reset   (reset),
                .dec     (dec),
                .rs_idx  (rs_idx),
                .rt_idx  (rt_idx),
                .rs_data (rs_data),
                .rt_data (rt_data),
                .wb_fwd  (wb_fwd),
                .res     (res)
        );

        reg_writeback u_writeback (
                .clk           (clk),
                .reset         (reset),
                .res           (res),
                .rs_idx        (rs_idx),
                .rt_idx        (rt_idx),
                .rs_data       (rs_data),
                .rt_data       (rt_data),
                .wb_fwd        (wb_fwd),
                .wb_valid      (wb_valid),
                .wb_dest       (wb_dest),
                .wb_data       (wb_data),
                .exc_overflow  (exc_overflow),
                .exc_undefined (exc_undefined)
        );

endmodule

`default_nettype wire

//--- test/mips_alu_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu_core_props (
        input logic clk,
        input logic reset,
        input logic inst_valid,
        input logic wb_valid,
        input logic exc_overflow,
        input logic exc_undefined
);

        a_one_pulse: assert property (@(posedge clk) disable iff (reset)
                $onehot0({wb_valid, exc_overflow, exc_undefined}))
                else $error("writeback and exception pulses overlap");

        a_reset_quiet: assert property (@(posedge clk)
                reset |=> !(wb_valid || exc_overflow || exc_undefined))
                else $error("output pulse in the cycle after reset");

        // Fixed three-edge pipeline latency
        a_wb_source: assert property (@(posedge clk) disable iff (reset)
                wb_valid |-> $past(inst_valid, 3))
                else $error("wb_valid without an instruction three edges earlier");

endmodule

bind mips_alu_core mips_alu_core_props u_props (
        .clk           (clk),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .wb_valid      (wb_valid),
        .exc_overflow  (exc_overflow),
        .exc_undefined (exc_undefined)
);

`default_nettype wire

//--- test/tb_mips_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_alu_core import mips_pkg::*; ();

        localparam int     N_INST  = 94;      // Instructions issued over all tests
        localparam longint MAX_S32 = 64'sd2147483647;
        localparam longint MIN_S32 = -64'sd2147483648;
        localparam logic [1:0] K_WRITE = 2'd0;
        localparam logic [1:0] K_OVF   = 2'd1;
        localparam logic [1:0] K_UNDEF = 2'd2;
        localparam opcode_t OP_LW      = 6'b100011;
        localparam opcode_t OP_BEQ     = 6'b000100;
        localparam funct_t  FN_MULT    = 6'b011000;
        localparam funct_t  FN_SYSCALL = 6'b001100;

        typedef struct packed {
                int         due;      // Cycle count when the pulse is visible
                logic [1:0] kind;
                reg_idx_t   dest;
                word_t      data;
        } exp_t;

        logic     clk = 1'b0;
        logic     reset;
        logic     inst_valid;
        word_t    instruction;
        logic     wb_valid;
        reg_idx_t wb_dest;
        word_t    wb_data;
        logic     exc_overflow;
        logic     exc_undefined;

        word_t model [32];
        exp_t  exp_q [$];
        exp_t  mon_e;
        int    cyc = 0;
        int    errors = 0;
        int    n_checks = 0;

        mips_alu_core UUT (
                .clk           (clk),
                .reset         (reset),
                .inst_valid    (inst_valid),
                .instruction   (instruction),
                .wb_valid      (wb_valid),
                .wb_dest       (wb_dest),
                .wb_data       (wb_data),
                .exc_overflow  (exc_overflow),
                .exc_undefined (exc_undefined)
        );

        always #2 clk = ~clk;

        always @(posedge clk) cyc <= cyc + 1;

        task automatic check_word(string name, word_t exp, word_t act);
                n_checks++;
                if (act !== exp) begin
                        $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
                        errors++;
                end
        endtask

        task automatic check_idx(string name, reg_idx_t exp, reg_idx_t act);
                n_checks++;
                if (act !== exp) begin
                        $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
                        errors++;
                end
        endtask

        task automatic check_flag(string name, logic exp, logic act);
                n_checks++;
                if (exp === 1'b1 && act !== 1'b1) begin
                        $display("ERROR at %0t: expected pulse on %s did not appear", $time, name);
                        errors++;
                end else if (act !== exp) begin
                        $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
                        errors++;
                end
        endtask

        // Outputs are stable at the falling edge
        always @(negedge clk) begin
                if (!reset) begin
                        if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                                mon_e = exp_q.pop_front();
                                check_flag("wb_valid", mon_e.kind == K_WRITE, wb_valid);
                                check_flag("exc_overflow", mon_e.kind == K_OVF, exc_overflow);
                                check_flag("exc_undefined", mon_e.kind == K_UNDEF, exc_undefined);
                                if (mon_e.kind == K_WRITE) begin
                                        check_idx("wb_dest", mon_e.dest, wb_dest);
                                        check_word("wb_data", mon_e.data, wb_data);
                                end
                        end else if (wb_valid || exc_overflow || exc_undefined) begin
                                $display("ERROR at %0t: output pulse with no instruction due", $time);
                                errors++;
                        end
                end
        end

        task automatic send(word_t inst, logic [1:0] kind, reg_idx_t dest, word_t data);
                exp_t e;
                if (kind == K_WRITE && dest != 5'd0)
                        model[dest] = data;
                @(posedge clk);
                #1;
                inst_valid  = 1'b1;
                instruction = inst;
                e.due  = cyc + 3;                 // Sampled next edge, out after two more
                e.kind = kind;
                e.dest = dest;
                e.data = data;
                exp_q.push_back(e);
        endtask

        task automatic issue_r(funct_t fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                               logic [4:0] sa);
                word_t  a;
                word_t  b;
                word_t  r;
                longint wide;
                a = model[rs];
                b = model[rt];
                wide = longint'($signed(a)) + longint'($signed(b));
                if (fn == FN_SUB || fn == FN_SUBU)
                        wide = longint'($signed(a)) - longint'($signed(b));
                case (fn)
                        FN_ADD, FN_ADDU: r = a + b;
                        FN_SUB, FN_SUBU: r = a - b;
                        FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLTU: r = (a < b) ? 32'd1 : 32'd0;
                        FN_AND:  r = a & b;
                        FN_OR:   r = a | b;
                        FN_XOR:  r = a ^ b;
                        FN_NOR:  r = ~(a | b);
                        FN_SLL:  r = b << sa;
                        FN_SRL:  r = b >> sa;
                        FN_SRA:  r = $signed(b) >>> sa;
                        FN_SLLV: r = b << a[4:0];
                        FN_SRLV: r = b >> a[4:0];
                        FN_SRAV: r = $signed(b) >>> a[4:0];
                        default: r = '0;
                endcase
                if ((fn == FN_ADD || fn == FN_SUB) && (wide > MAX_S32 || wide < MIN_S32))
                        send({OP_SPECIAL, rs, rt, rd, sa, fn}, K_OVF, rd, r);
                else
                        send({OP_SPECIAL, rs, rt, rd, sa, fn}, K_WRITE, rd, r);
        endtask

        task automatic issue_i(opcode_t op, reg_idx_t rt, reg_idx_t rs, logic [15:0] imm);
                word_t  a;
                word_t  se;
                word_t  ze;
                word_t  r;
                longint wide;
                a  = model[rs];
                se = {{16{imm[15]}}, imm};
                ze = {16'h0000, imm};
                wide = longint'($signed(a)) + longint'($signed(se));
                case (op)
                        OP_ADDI, OP_ADDIU: r = a + se;
                        OP_SLTI:  r = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
                        OP_SLTIU: r = (a < se) ? 32'd1 : 32'd0; // Unsigned against sign-extended
                        OP_ANDI:  r = a & ze;
                        OP_ORI:   r = a | ze;
                        OP_XORI:  r = a ^ ze;
                        OP_LUI:   r = {imm, 16'h0000};
                        default:  r = '0;
                endcase
                if (op == OP_ADDI && (wide > MAX_S32 || wide < MIN_S32))
                        send({op, rs, rt, imm}, K_OVF, rt, r);
                else
                        send({op, rs, rt, imm}, K_WRITE, rt, r);
        endtask

        task automatic load_word(reg_idx_t rd, word_t v);
                issue_i(OP_LUI, rd, 5'd0, v[31:16]);
                issue_i(OP_ORI, rd, rd, v[15:0]);
        endtask

        task automatic wait_drain();
                int n;
                @(posedge clk);
                #1;
                inst_valid = 1'b0;
                n = 0;
                while (exp_q.size() != 0 && n < 8) begin
                        @(posedge clk);
                        n++;
                end
                if (exp_q.size() != 0) begin
                        $display("ERROR at %0t: %0d results never appeared", $time, exp_q.size());
                        errors++;
                        exp_q.delete();
                end
        endtask

        task automatic test_imm_loads();
                logic [15:0] imm;
                for (int i = 0; i < 4; i++) begin
                        imm = 16'($urandom);
                        imm[15] = i[0];               // Alternate the sign bit
                        issue_i(OP_ADDIU, 5'd1, 5'd0, imm);
                        issue_i(OP_ORI, 5'd2, 5'd0, imm);
                        issue_i(OP_LUI, 5'd3, 5'd0, imm);
                        issue_i(OP_ANDI, 5'd4, 5'd1, imm);
                        issue_i(OP_XORI, 5'd5, 5'd1, imm);
                end
                wait_drain();
        endtask

        task automatic test_forwarding();
                load_word(5'd1, $urandom);
                load_word(5'd2, $urandom);
                issue_r(FN_ADDU, 5'd3, 5'd1, 5'd2, 5'd0);
                issue_r(FN_SUBU, 5'd4, 5'd3, 5'd1, 5'd0);
                issue_r(FN_AND, 5'd5, 5'd4, 5'd3, 5'd0);
                issue_r(FN_OR, 5'd6, 5'd5, 5'd4, 5'd0);
                issue_r(FN_XOR, 5'd7, 5'd6, 5'd5, 5'd0);
                issue_r(FN_NOR, 5'd8, 5'd7, 5'd6, 5'd0);
                issue_r(FN_ADDU, 5'd9, 5'd8, 5'd3, 5'd0); // r3 from the register file
                wait_drain();
        endtask

        task automatic test_shifts();
                word_t      v;
                logic [4:0] sa;
                for (int i = 0; i < 3; i++) begin
                        v = $urandom;
                        v[31] = ~i[0];                // Negative values for SRA
                        sa = 5'($urandom);
                        load_word(5'd10, v);
                        load_word(5'd11, $urandom);
                        issue_r(FN_SLL, 5'd12, 5'd0, 5'd10, sa);
                        issue_r(FN_SRL, 5'd13, 5'd0, 5'd10, sa);
                        issue_r(FN_SRA, 5'd14, 5'd0, 5'd10, sa);
                        issue_r(FN_SLLV, 5'd15, 5'd11, 5'd10, 5'd0);
                        issue_r(FN_SRLV, 5'd16, 5'd11, 5'd10, 5'd0);
                        issue_r(FN_SRAV, 5'd17, 5'd11, 5'd10, 5'd0);
                end
                wait_drain();
        endtask

        task automatic test_compares();
                load_word(5'd14, {1'b1, 31'($urandom)});
                load_word(5'd15, {1'b0, 31'($urandom)});
                issue_r(FN_SLT, 5'd16, 5'd14, 5'd15, 5'd0);
                issue_r(FN_SLTU, 5'd16, 5'd14, 5'd15, 5'd0);
                issue_r(FN_SLT, 5'd16, 5'd15, 5'd14, 5'd0);
                issue_r(FN_SLTU, 5'd16, 5'd15, 5'd14, 5'd0);
                issue_i(OP_SLTI, 5'd17, 5'd14, 16'h0001);
                issue_i(OP_SLTIU, 5'd17, 5'd14, 16'h0001);
                issue_i(OP_SLTI, 5'd17, 5'd15, 16'h8000);
                issue_i(OP_SLTIU, 5'd17, 5'd15, 16'h8000);
                wait_drain();
        endtask

        task automatic test_overflow();
                load_word(5'd18, 32'h7fff_fff0);
                load_word(5'd19, 32'h0000_0100);
                load_word(5'd20, $urandom);
                load_word(5'd21, 32'h8000_0000);
                issue_r(FN_ADD, 5'd20, 5'd18, 5'd19, 5'd0);
                issue_r(FN_ADDU, 5'd22, 5'd20, 5'd0, 5'd0);  // Old r20 expected
                issue_i(OP_ADDI, 5'd20, 5'd18, 16'h7fff);
                issue_r(FN_ADDU, 5'd22, 5'd20, 5'd0, 5'd0);
                issue_r(FN_SUB, 5'd20, 5'd21, 5'd19, 5'd0);
                issue_r(FN_ADDU, 5'd22, 5'd20, 5'd0, 5'd0);
                wait_drain();
        endtask

        task automatic test_undefined();
                send({OP_SPECIAL, 5'd1, 5'd2, 10'd0, FN_MULT}, K_UNDEF, 5'd0, '0);
                send({OP_LW, 5'd0, 5'd1, 16'h0010}, K_UNDEF, 5'd0, '0);
                send({OP_BEQ, 5'd1, 5'd1, 16'h0004}, K_UNDEF, 5'd0, '0);
                send({OP_SPECIAL, 20'd0, FN_SYSCALL}, K_UNDEF, 5'd0, '0);
                issue_r(FN_ADDU, 5'd23, 5'd1, 5'd0, 5'd0);   // r1 untouched by LW
                issue_i(OP_ADDIU, 5'd0, 5'd0, 16'($urandom) | 16'h0001);
                issue_r(FN_ADDU, 5'd24, 5'd0, 5'd0, 5'd0);
                wait_drain();
        endtask

        initial begin
                #((N_INST + 20) * 4 * 2);
                $display("ERROR at %0t: watchdog expired before the tests finished", $time);
                $display("TESTBENCH FAILED");
                $finish;
        end

        initial begin
                void'($urandom(97803));
                reset       = 1'b1;
                inst_valid  = 1'b0;
                instruction = '0;
                for (int i = 0; i < 32; i++)
                        model[i] = '0;
                repeat (8) @(posedge clk);
                #1;
                reset = 1'b0;
                test_imm_loads();
                test_forwarding();
                test_shifts();
                test_compares();
                test_overflow();
                test_undefined();
                $display("Checks: %0d, errors: %0d", n_checks, errors);
                if (errors == 0)
                        $display("TESTBENCH PASSED");
                else
                        $display("TESTBENCH FAILED");
                $finish;
        end

endmodule

`default_nettype wire

//--- sources.f
hw/mips_pkg.sv
hw/inst_decoder.sv
hw/alu_execute.sv
hw/reg_writeback.sv
hw/mips_alu_core.sv
test/mips_alu_core_props.sv
test/tb_mips_alu_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_alu_core
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  := TESTBENCH PASSED
FAIL_MSG  := TESTBENCH FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
